// File: logic/iopage_bus_pkg.sv
/*
   bus-side types for the I/O page: APB completer request and response, and
   the internal access word that is broadcast to every unit
*/
package iopage_bus_pkg;

   // page offset and bus word widths
   localparam int PAGE_AW = 13;
   localparam int DATA_W = 16;

   // as driven by the requester, held stable until pready
   typedef struct packed
   {
      logic psel;
      logic penable;
      logic pwrite;
      logic [PAGE_AW-1:0] paddr;
      logic [DATA_W-1:0] pwdata;
      logic [DATA_W/8-1:0] pstrb;
   } iopage_apb_req_t;

   typedef struct packed
   {
      logic [DATA_W-1:0] prdata;
      logic pready;
      logic pslverr;
   } iopage_apb_rsp_t;

   // valid for exactly one cycle per transfer
   typedef struct packed
   {
      logic valid;
      logic write;
      logic [1:0] reg_idx;
      logic [DATA_W/8-1:0] strb;
      logic [DATA_W-1:0] wdata;
   } iopage_access_t;

endpackage

// File: logic/iopage_dev_pkg.sv
/*
   register map and CSR layout of one interval clock unit
   only the low byte of the CSR carries bits, the high byte reads zero
*/
package iopage_dev_pkg;

   // word index within a unit slot, index 3 is unmapped
   localparam logic [1:0] REG_CSR = 2'd0;
   localparam logic [1:0] REG_RELOAD = 2'd1;
   localparam logic [1:0] REG_COUNT = 2'd2;

   // registers per slot, one slot spans 8 bytes
   localparam int SLOT_WORDS = 4;

   // status as read back
   typedef struct packed
   {
      logic [7:0] zero_hi;
      logic done;
      logic ie;
      logic [4:0] zero_mid;
      logic run;
   } iopage_csr_sts_t;

   // control as written, clr_done is write one to clear
   typedef struct packed
   {
      logic [7:0] unused_hi;
      logic clr_done;
      logic ie;
      logic [4:0] unused_mid;
      logic run;
   } iopage_csr_ctl_t;

   typedef union packed
   {
      iopage_csr_sts_t sts;
      iopage_csr_ctl_t ctl;
   } iopage_csr_u;

   typedef struct packed
   {
      logic req;
      logic [7:0] vector;
   } iopage_intr_t;

endpackage

// File: logic/iopage_apb_decode.sv
/*
   APB completer with one fixed wait state: setup, access, then pready
   a hit needs a word-aligned offset inside the unit slots and a mapped register
*/
module iopage_apb_decode
#(
   parameter int N_UNITS = 4,
   parameter logic [iopage_bus_pkg::PAGE_AW-1:0] BASE_ADDR = 13'o17540
)
(
   input logic clk,
   input logic reset,
   input iopage_bus_pkg::iopage_apb_req_t apb_req,
   output logic pready,
   output iopage_bus_pkg::iopage_access_t access,
   output logic [N_UNITS-1:0] sel
);

   import iopage_bus_pkg::*;
   import iopage_dev_pkg::*;

   localparam int SLOT_SHIFT = $clog2(SLOT_WORDS) + 1;
   localparam logic [PAGE_AW-1:0] SPAN = PAGE_AW'(N_UNITS * SLOT_WORDS * 2);

   logic phase_c;
   logic [PAGE_AW-1:0] offset;
   logic [PAGE_AW-1:0] slot;
   logic [1:0] reg_idx;
   logic addr_hit;

   // high during cycle C only
   always_ff @(posedge clk)
   begin
      if (reset)
         phase_c <= 1'b0;
      else
         phase_c <= apb_req.psel && apb_req.penable && !phase_c;
   end

   assign pready = phase_c;

   assign offset = apb_req.paddr - BASE_ADDR;
   assign slot = offset >> SLOT_SHIFT;
   assign reg_idx = offset[SLOT_SHIFT-1:1];

   assign addr_hit = (apb_req.paddr >= BASE_ADDR) && (offset < SPAN) &&
                     !offset[0] && (reg_idx <= REG_COUNT);

   // first access cycle only
   always_comb
   begin
      access.valid = apb_req.psel && apb_req.penable && !phase_c;
      access.write = apb_req.pwrite;
      access.reg_idx = reg_idx;
      access.strb = apb_req.pstrb;
      access.wdata = apb_req.pwdata;
   end

   always_comb
   begin
      for (int i = 0; i < N_UNITS; i++)
         sel[i] = access.valid && addr_hit && (slot == PAGE_AW'(i));
   end

   // direction, data and strobes are held like the address
   assert property (@(posedge clk) disable iff (reset)
      apb_req.psel && !pready |=> $stable({apb_req.pwrite, apb_req.pwdata, apb_req.pstrb}));

   // requester holds the address through the wait state
   assert property (@(posedge clk) disable iff (reset)
      apb_req.psel && !pready |=> $stable(apb_req.paddr));

endmodule

// File: logic/iopage_clock_unit.sv
/*
   interval clock: counts down from reload while run is set, sets done on expiry
   count is read only, writes to it are accepted and dropped
*/
module iopage_clock_unit
#(
   parameter int UNIT_INDEX = 0,
   parameter logic [7:0] VEC_BASE = 8'o100
)
(
   input logic clk,
   input logic reset,
   input iopage_bus_pkg::iopage_access_t access,
   input logic hit,
   input logic intr_ack,
   output logic [iopage_bus_pkg::DATA_W-1:0] rdata,
   output iopage_dev_pkg::iopage_intr_t intr
);

   import iopage_bus_pkg::*;
   import iopage_dev_pkg::*;

   // four vector words per unit
   localparam logic [7:0] VEC = VEC_BASE + 8'(4 * UNIT_INDEX);

   iopage_csr_u csr_q;
   iopage_csr_u wr_csr;
   logic [DATA_W-1:0] reload_q;
   logic [DATA_W-1:0] count_q;
   logic wr_en;
   logic csr_wr;
   logic reload_wr;
   logic expire;

   assign wr_en = hit && access.valid && access.write;
   assign csr_wr = wr_en && (access.reg_idx == REG_CSR) && access.strb[0];
   assign reload_wr = wr_en && (access.reg_idx == REG_RELOAD);
   assign wr_csr = access.wdata;
   assign expire = csr_q.sts.run && (count_q == '0);

   // later assignments win: expiry, then write, then acknowledge
   always_ff @(posedge clk)
   begin
      if (reset)
         csr_q <= '0;
      else
      begin
         if (expire)
            csr_q.sts.done <= 1'b1;
         if (csr_wr)
         begin
            csr_q.sts.ie <= wr_csr.ctl.ie;
            csr_q.sts.run <= wr_csr.ctl.run;
            if (wr_csr.ctl.clr_done)
               csr_q.sts.done <= 1'b0;
         end
         if (intr_ack)
            csr_q.sts.done <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         reload_q <= '0;
         count_q <= '0;
      end
      else
      begin
         if (reload_wr && access.strb[0])
            reload_q[7:0] <= access.wdata[7:0];
         if (reload_wr && access.strb[1])
            reload_q[15:8] <= access.wdata[15:8];
         // idle or expired: follow reload
         if (!csr_q.sts.run || expire)
            count_q <= reload_q;
         else
            count_q <= count_q - 1'b1;
      end
   end

   // sampled at the end of the access cycle
   always_ff @(posedge clk)
   begin
      if (hit && access.valid)
      begin
         case (access.reg_idx)
            REG_CSR:
               rdata <= {8'b0, csr_q.sts.done, csr_q.sts.ie, 5'b0, csr_q.sts.run};
            REG_RELOAD:
               rdata <= reload_q;
            REG_COUNT:
               rdata <= count_q;
            default:
               rdata <= '0;
         endcase
      end
   end

   assign intr.req = csr_q.sts.done && csr_q.sts.ie;
   assign intr.vector = VEC;

   // collector only steers an ack to a unit that is requesting
   assert property (@(posedge clk) disable iff (reset) intr_ack |-> intr.req);

endmodule

// File: logic/iopage_collect.sv
/*
   read data and error for cycle C, fixed-priority interrupt choice
   lowest unit index wins; pslverr only has meaning alongside pready
*/
module iopage_collect
#(
   parameter int N_UNITS = 4
)
(
   input logic clk,
   input logic reset,
   input logic [N_UNITS-1:0] sel,
   input logic [iopage_bus_pkg::DATA_W-1:0] unit_rdata [N_UNITS],
   input iopage_dev_pkg::iopage_intr_t unit_intr [N_UNITS],
   input logic intr_ack,
   output logic [iopage_bus_pkg::DATA_W-1:0] prdata,
   output logic pslverr,
   output iopage_dev_pkg::iopage_intr_t intr,
   output logic [N_UNITS-1:0] unit_ack
);

   import iopage_bus_pkg::*;

   logic [N_UNITS-1:0] sel_q;
   logic [N_UNITS-1:0] grant;

   // sel from cycle B steers cycle C
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         sel_q <= '0;
         pslverr <= 1'b0;
      end
      else
      begin
         sel_q <= sel;
         pslverr <= (sel == '0);
      end
   end

   // zero when nothing decoded
   always_comb
   begin
      prdata = '0;
      for (int i = 0; i < N_UNITS; i++)
         prdata = prdata | (unit_rdata[i] & {DATA_W{sel_q[i]}});
   end

   // scan downward so the lowest requester is kept
   always_comb
   begin
      grant = '0;
      intr = '0;
      for (int i = N_UNITS - 1; i >= 0; i--)
      begin
         if (unit_intr[i].req)
         begin
            grant = '0;
            grant[i] = 1'b1;
            intr = unit_intr[i];
         end
      end
   end

   assign unit_ack = grant & {N_UNITS{intr_ack}};

endmodule

// File: logic/iopage_top.sv
/*
   I/O page of N_UNITS interval clocks behind one APB completer port
   unit i sits at BASE_ADDR + 8*i and interrupts at VEC_BASE + 4*i
*/
module iopage_top
#(
   parameter int N_UNITS = 4,
   parameter logic [iopage_bus_pkg::PAGE_AW-1:0] BASE_ADDR = 13'o17540,
   parameter logic [7:0] VEC_BASE = 8'o100
)
(
   input logic clk,
   input logic reset,
   input iopage_bus_pkg::iopage_apb_req_t apb_req,
   output iopage_bus_pkg::iopage_apb_rsp_t apb_rsp,
   output iopage_dev_pkg::iopage_intr_t intr,
   input logic intr_ack
);

   import iopage_bus_pkg::*;
   import iopage_dev_pkg::*;

   iopage_access_t access;
   logic [N_UNITS-1:0] sel;
   logic [N_UNITS-1:0] unit_ack;
   logic [DATA_W-1:0] unit_rdata [N_UNITS];
   iopage_intr_t unit_intr [N_UNITS];

   iopage_apb_decode #(.N_UNITS(N_UNITS), .BASE_ADDR(BASE_ADDR)) u_decode
   (
      .clk(clk),
      .reset(reset),
      .apb_req(apb_req),
      .pready(apb_rsp.pready),
      .access(access),
      .sel(sel)
   );

   for (genvar i = 0; i < N_UNITS; i++)
   begin : g_unit
      iopage_clock_unit #(.UNIT_INDEX(i), .VEC_BASE(VEC_BASE)) u_clock_unit
      (
         .clk(clk),
         .reset(reset),
         .access(access),
         .hit(sel[i]),
         .intr_ack(unit_ack[i]),
         .rdata(unit_rdata[i]),
         .intr(unit_intr[i])
      );
   end

   iopage_collect #(.N_UNITS(N_UNITS)) u_collect
   (
      .clk(clk),
      .reset(reset),
      .sel(sel),
      .unit_rdata(unit_rdata),
      .unit_intr(unit_intr),
      .intr_ack(intr_ack),
      .prdata(apb_rsp.prdata),
      .pslverr(apb_rsp.pslverr),
      .intr(intr),
      .unit_ack(unit_ack)
   );

endmodule

// File: verification/iopage_tb.sv
/*
   directed tests through the APB port, one idle cycle between transfers
   reload values are tracked in a model here, the first mismatch ends the run
*/
module iopage_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import iopage_bus_pkg::*;
   import iopage_dev_pkg::*;

   localparam int N_UNITS = 4;
   localparam logic [PAGE_AW-1:0] BASE_ADDR = 13'o17540;
   localparam logic [7:0] VEC_BASE = 8'o100;
   localparam int CLK_PERIOD = 10;
   // rough length of all tests in cycles, watchdog allows four times that
   localparam int TEST_CYCLES = 500;
   localparam int WATCHDOG_NS = 4 * TEST_CYCLES * CLK_PERIOD;
   localparam int SEED = 32'h5e12;

   // CSR bits as read back
   localparam logic [DATA_W-1:0] CSR_DONE = 16'h0080;
   localparam logic [DATA_W-1:0] CSR_IE = 16'h0040;
   localparam logic [DATA_W-1:0] CSR_RUN = 16'h0001;

   logic clk;
   logic reset;
   iopage_apb_req_t apb_req;
   iopage_apb_rsp_t apb_rsp;
   iopage_intr_t intr;
   logic intr_ack;
   logic [DATA_W-1:0] reload_model [N_UNITS];

   iopage_top #(.N_UNITS(N_UNITS), .BASE_ADDR(BASE_ADDR), .VEC_BASE(VEC_BASE)) u_iopage_top
   (
      .clk(clk),
      .reset(reset),
      .apb_req(apb_req),
      .apb_rsp(apb_rsp),
      .intr(intr),
      .intr_ack(intr_ack)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      if (act !== exp)
         abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_err(input string name, input logic exp, input logic act);
      if (act !== exp)
         abort_run($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
   endtask

   // vector only matters while req is high
   task automatic check_intr(input string name, input iopage_intr_t exp,
                             input iopage_intr_t act);
      if (act.req !== exp.req || (exp.req && act.vector !== exp.vector))
         abort_run($sformatf("CHECK FAILED %s expected req %b vec %o actual req %b vec %o",
                             name, exp.req, exp.vector, act.req, act.vector));
   endtask

   function automatic logic [PAGE_AW-1:0] unit_reg_addr(input int unit, input logic [1:0] idx);
      return BASE_ADDR + PAGE_AW'(unit * SLOT_WORDS * 2 + 2 * int'(idx));
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] new_word,
                                                     input logic [1:0] strb);
      logic [DATA_W-1:0] result;
      result = old_word;
      for (int b = 0; b < 2; b++)
         if (strb[b])
            result[8*b +: 8] = new_word[8*b +: 8];
      return result;
   endfunction

   // setup, access with pready low, then pready high
   task automatic apb_transfer(input logic write, input logic [PAGE_AW-1:0] addr,
                               input logic [DATA_W-1:0] wdata, input logic [1:0] strb,
                               output logic [DATA_W-1:0] rdata, output logic err);
      @(posedge clk);
      apb_req.psel <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite <= write;
      apb_req.paddr <= addr;
      apb_req.pwdata <= wdata;
      apb_req.pstrb <= strb;
      @(posedge clk);
      apb_req.penable <= 1'b1;
      @(negedge clk);
      if (apb_rsp.pready !== 1'b0)
         abort_run("pready came in the first access cycle instead of the one after it");
      @(posedge clk);
      @(negedge clk);
      if (apb_rsp.pready !== 1'b1)
         abort_run($sformatf("no pready in the third cycle of the transfer to %o", addr));
      rdata = apb_rsp.prdata;
      err = apb_rsp.pslverr;
      @(posedge clk);
      apb_req <= '0;
   endtask

   task automatic apb_write(input logic [PAGE_AW-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [1:0] strb, output logic err);
      logic [DATA_W-1:0] unused_rdata;
      apb_transfer(1'b1, addr, data, strb, unused_rdata, err);
   endtask

   task automatic apb_read(input logic [PAGE_AW-1:0] addr, output logic [DATA_W-1:0] data,
                           output logic err);
      apb_transfer(1'b0, addr, '0, 2'b00, data, err);
   endtask

   task automatic write_ok(input string name, input logic [PAGE_AW-1:0] addr,
                           input logic [DATA_W-1:0] data, input logic [1:0] strb);
      logic err;
      apb_write(addr, data, strb, err);
      check_err({name, " pslverr"}, 1'b0, err);
   endtask

   task automatic read_expect(input string name, input logic [PAGE_AW-1:0] addr,
                              input logic [DATA_W-1:0] exp);
      logic [DATA_W-1:0] data;
      logic err;
      apb_read(addr, data, err);
      check_err({name, " pslverr"}, 1'b0, err);
      check_data(name, exp, data);
   endtask

   task automatic pulse_ack();
      @(posedge clk);
      intr_ack <= 1'b1;
      @(posedge clk);
      intr_ack <= 1'b0;
      @(negedge clk);
   endtask

   task automatic test_reset();
      for (int u = 0; u < N_UNITS; u++)
      begin
         reload_model[u] = '0;
         read_expect($sformatf("reset csr unit %0d", u), unit_reg_addr(u, REG_CSR), '0);
         read_expect($sformatf("reset reload unit %0d", u), unit_reg_addr(u, REG_RELOAD), '0);
      end
      @(negedge clk);
      check_intr("reset intr", '0, intr);
   endtask

   task automatic test_reload();
      logic [DATA_W-1:0] data;
      logic [1:0] strb;
      string name;
      for (int u = 0; u < N_UNITS; u++)
      begin
         for (int n = 0; n < 3; n++)
         begin
            name = $sformatf("reload unit %0d pass %0d", u, n);
            data = DATA_W'($urandom);
            strb = 2'($urandom);
            write_ok(name, unit_reg_addr(u, REG_RELOAD), data, strb);
            reload_model[u] = merge_bytes(reload_model[u], data, strb);
            read_expect(name, unit_reg_addr(u, REG_RELOAD), reload_model[u]);
            // count ignores the write and follows reload while stopped
            write_ok(name, unit_reg_addr(u, REG_COUNT), DATA_W'($urandom), 2'b11);
            read_expect({name, " count"}, unit_reg_addr(u, REG_COUNT), reload_model[u]);
         end
      end
   endtask

   task automatic test_decode_errors();
      logic [PAGE_AW-1:0] bad_addr [4];
      logic [DATA_W-1:0] data;
      logic err;
      bad_addr[0] = BASE_ADDR - 13'd2;
      bad_addr[1] = BASE_ADDR + PAGE_AW'(N_UNITS * SLOT_WORDS * 2);
      bad_addr[2] = BASE_ADDR + 13'd1;
      bad_addr[3] = unit_reg_addr(1, 2'd3);
      for (int i = 0; i < 4; i++)
      begin
         apb_write(bad_addr[i], 16'hffff, 2'b11, err);
         check_err($sformatf("bad write %o", bad_addr[i]), 1'b1, err);
         apb_read(bad_addr[i], data, err);
         check_err($sformatf("bad read %o", bad_addr[i]), 1'b1, err);
         check_data($sformatf("bad read %o data", bad_addr[i]), '0, data);
      end
      for (int u = 0; u < N_UNITS; u++)
      begin
         read_expect($sformatf("after errors csr %0d", u), unit_reg_addr(u, REG_CSR), '0);
         read_expect($sformatf("after errors reload %0d", u), unit_reg_addr(u, REG_RELOAD),
                     reload_model[u]);
      end
   endtask

   task automatic test_expiry();
      int unsigned r;
      r = $urandom_range(12, 3);
      reload_model[2] = DATA_W'(r);
      write_ok("expiry reload", unit_reg_addr(2, REG_RELOAD), reload_model[2], 2'b11);
      write_ok("expiry start", unit_reg_addr(2, REG_CSR), CSR_RUN, 2'b11);
      repeat (r + 4) @(posedge clk);
      read_expect("expiry done set", unit_reg_addr(2, REG_CSR), CSR_DONE | CSR_RUN);
      // clr_done shares bit 7 with done
      write_ok("expiry clear", unit_reg_addr(2, REG_CSR), CSR_DONE | CSR_IE, 2'b11);
      read_expect("expiry done cleared", unit_reg_addr(2, REG_CSR), CSR_IE);
      repeat (r + 4) @(posedge clk);
      read_expect("expiry stopped", unit_reg_addr(2, REG_CSR), CSR_IE);
      write_ok("expiry idle", unit_reg_addr(2, REG_CSR), '0, 2'b11);
   endtask

   task automatic test_interrupts();
      iopage_intr_t exp;
      reload_model[1] = 16'd2;
      reload_model[3] = 16'd5;
      write_ok("intr reload 1", unit_reg_addr(1, REG_RELOAD), reload_model[1], 2'b11);
      write_ok("intr reload 3", unit_reg_addr(3, REG_RELOAD), reload_model[3], 2'b11);
      write_ok("intr start 3", unit_reg_addr(3, REG_CSR), CSR_IE | CSR_RUN, 2'b11);
      write_ok("intr start 1", unit_reg_addr(1, REG_CSR), CSR_IE | CSR_RUN, 2'b11);
      repeat (5 + 4) @(posedge clk);
      // stop both, done stays set
      write_ok("intr stop 1", unit_reg_addr(1, REG_CSR), CSR_IE, 2'b11);
      write_ok("intr stop 3", unit_reg_addr(3, REG_CSR), CSR_IE, 2'b11);
      @(negedge clk);
      exp.req = 1'b1;
      exp.vector = VEC_BASE + 8'd4;
      check_intr("intr unit 1 first", exp, intr);
      pulse_ack();
      exp.vector = VEC_BASE + 8'd12;
      check_intr("intr unit 3 after ack", exp, intr);
      pulse_ack();
      exp = '0;
      check_intr("intr idle after acks", exp, intr);
      read_expect("intr unit 1 csr", unit_reg_addr(1, REG_CSR), CSR_IE);
      read_expect("intr unit 3 csr", unit_reg_addr(3, REG_CSR), CSR_IE);
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      abort_run("watchdog expired before the tests finished");
   end

   initial
   begin
      int unsigned seed_ret;
      clk = 1'b0;
      reset = 1'b1;
      apb_req = '0;
      intr_ack = 1'b0;
      seed_ret = $urandom(SEED);
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      test_reset();
      test_reload();
      test_decode_errors();
      test_expiry();
      test_interrupts();
      $display("TESTS PASSED");
      $finish;
   end

endmodule

// File: files.f
logic/iopage_bus_pkg.sv
logic/iopage_dev_pkg.sv
logic/iopage_apb_decode.sv
logic/iopage_clock_unit.sv
logic/iopage_collect.sv
logic/iopage_top.sv
verification/iopage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the I/O page testbench with Verilator, result is read from sim.log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f \
   --top-module iopage_tb -o iopage_sim
./obj_dir/iopage_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "TESTS PASSED" sim.log
